// File: all.f
+incdir+include
hw/neuron_state_pkg.sv
hw/synapse_pkg.sv
hw/addr_reg_ram.sv
hw/neuron_state_mem.sv
hw/weight_fifo.sv
hw/status_mem.sv
verif/status_mem_checker.sv
verif/status_mem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the status memory testbench with Verilator and run it.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f all.f \
	--top-module status_mem_tb -o status_mem_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/status_mem_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "=== PASS ==="; then
	exit 0
fi
exit 1

// File: verif/status_mem_tb.sv
/*
 * Testbench top for the core status memory.
 * Drives every port with LFSR data 1 ns after the rising edge and
 * leaves the comparing to status_mem_checker.
 */
module status_mem_tb
	import neuron_state_pkg::*;
	import synapse_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_FIELD = 24;
	localparam int N_MULTI = 8;
	localparam int N_HIST = 24;
	localparam int N_WEIGHT = 24;
	localparam int N_REREAD = 8;
	localparam int N_CLEAR = 4;
	// reset plus each phase in the order driven below
	localparam int TEST_CYCLES = 3 + 2 * N_FIELD + 9 * N_MULTI + 4 * N_HIST
		+ 2 * N_WEIGHT + N_WEIGHT + 2 * N_REREAD + 3 + 8 + 2 * N_CLEAR + 6;
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

	logic clk;
	logic rst_n;
	logic start;
	state_rd_addr_t state_rd_addr;
	state_en_t state_rd_en;
	state_en_t state_wr_en;
	state_wr_t state_wr;
	syn_rd_t hist_rd;
	hist_wr_t hist_wr;
	syn_rd_t weight_rd;
	weight_wr_t weight_wr;
	logic fifo_rd_en;
	state_word_t state_rd_data;
	hist_t hist_rd_data;
	weight_t weight_rd_data;
	weight_t fifo_data;
	int error_count;
	int check_count;
	int cycles;

	logic [31:0] lfsr = 32'hb809;
	neuron_addr_t nrn;
	state_field_e fld;
	state_en_t en_mask;
	synapse_addr_t addr;
	neuron_addr_t neurons [$];
	state_field_e fields [$];
	synapse_addr_t syn_addrs [$];

	status_mem u_status_mem (
		.clk_i            (clk),
		.rst_n_i          (rst_n),
		.start_i          (start),
		.state_rd_addr_i  (state_rd_addr),
		.state_rd_en_i    (state_rd_en),
		.state_wr_en_i    (state_wr_en),
		.state_wr_i       (state_wr),
		.hist_rd_i        (hist_rd),
		.hist_wr_i        (hist_wr),
		.weight_rd_i      (weight_rd),
		.weight_wr_i      (weight_wr),
		.fifo_rd_en_i     (fifo_rd_en),
		.state_rd_data_o  (state_rd_data),
		.hist_rd_data_o   (hist_rd_data),
		.weight_rd_data_o (weight_rd_data),
		.fifo_data_o      (fifo_data)
	);

	status_mem_checker u_checker (
		.clk_i            (clk),
		.rst_n_i          (rst_n),
		.start_i          (start),
		.state_rd_addr_i  (state_rd_addr),
		.state_rd_en_i    (state_rd_en),
		.state_wr_en_i    (state_wr_en),
		.state_wr_i       (state_wr),
		.hist_rd_i        (hist_rd),
		.hist_wr_i        (hist_wr),
		.weight_rd_i      (weight_rd),
		.weight_wr_i      (weight_wr),
		.fifo_rd_en_i     (fifo_rd_en),
		.state_rd_data_i  (state_rd_data),
		.hist_rd_data_i   (hist_rd_data),
		.weight_rd_data_i (weight_rd_data),
		.fifo_data_i      (fifo_data),
		.error_count_o    (error_count),
		.check_count_o    (check_count)
	);

	// right-shift Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++)
		begin
			value = {value[30:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
		end
		return value;
	endfunction

	// bias is the top bit of the enable struct
	function automatic state_en_t field_en(state_field_e f);
		return state_en_t'(4'b1000 >> f);
	endfunction

	// every enable low again for the new cycle
	task automatic next_cycle();
		@(posedge clk);
		#1;
		start = 1'b0;
		state_rd_en = '0;
		state_wr_en = '0;
		hist_rd.en = 1'b0;
		hist_wr.en = 1'b0;
		weight_rd.en = 1'b0;
		weight_wr.en = 1'b0;
		fifo_rd_en = 1'b0;
	endtask

	task automatic write_state(state_en_t en, neuron_addr_t neuron, state_word_t data);
		next_cycle();
		state_wr_en = en;
		state_wr.addr = neuron;
		state_wr.data = data;
	endtask

	task automatic read_state(state_field_e field, neuron_addr_t neuron);
		next_cycle();
		state_rd_en = field_en(field);
		state_rd_addr.neuron = neuron;
		state_rd_addr.field = field;
	endtask

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial
	begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, stimulus did not finish", cycles);
		$display("=== FAIL ===");
		$finish;
	end

	initial
	begin
		rst_n = 1'b0;
		start = 1'b0;
		state_rd_addr = '0;
		state_rd_en = '0;
		state_wr_en = '0;
		state_wr = '0;
		hist_rd = '0;
		hist_wr = '0;
		weight_rd = '0;
		weight_wr = '0;
		fifo_rd_en = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// single-field writes, each read back a cycle later
		for (int i = 0; i < N_FIELD; i++)
		begin
			nrn = neuron_addr_t'(rand_bits(8));
			fld = state_field_e'(2'(rand_bits(2)));
			neurons.push_back(nrn);
			fields.push_back(fld);
			write_state(field_en(fld), nrn, state_word_t'(rand_bits(16)));
		end
		for (int i = 0; i < N_FIELD; i++)
			read_state(fields[i], neurons[i]);

		// distinct word per field, then one word into a subset
		for (int i = 0; i < N_MULTI; i++)
		begin
			nrn = neuron_addr_t'(rand_bits(8));
			for (int f = 0; f < 4; f++)
				write_state(field_en(state_field_e'(f)), nrn, state_word_t'(rand_bits(16)));
			en_mask = state_en_t'(rand_bits(4));
			if (en_mask == '0)
				en_mask = state_en_t'(4'b1010);
			write_state(en_mask, nrn, state_word_t'(rand_bits(16)));
			for (int f = 0; f < 4; f++)
				read_state(state_field_e'(f), nrn);
		end

		// history read, then held while the read address moves to a fresh write
		for (int i = 0; i < N_HIST; i++)
		begin
			addr = synapse_addr_t'(rand_bits(16));
			next_cycle();
			hist_wr = {1'b1, addr, hist_t'(rand_bits(8))};
			next_cycle();
			hist_rd = {1'b1, addr};
			next_cycle();
			hist_rd = {1'b0, synapse_addr_t'(rand_bits(16))};
			hist_wr = {1'b1, hist_rd.addr, hist_t'(rand_bits(8))};
			next_cycle();
		end

		// every weight read also lands in the FIFO
		for (int i = 0; i < N_WEIGHT; i++)
		begin
			addr = synapse_addr_t'(rand_bits(16));
			syn_addrs.push_back(addr);
			next_cycle();
			weight_wr = {1'b1, addr, weight_t'(rand_bits(16))};
			next_cycle();
			weight_rd = {1'b1, addr};
		end
		for (int i = 0; i < N_WEIGHT; i++)
		begin
			next_cycle();
			fifo_rd_en = 1'b1;
		end

		// head must hold with no pop
		for (int i = 0; i < N_REREAD; i++)
		begin
			next_cycle();
			weight_rd = {1'b1, syn_addrs[i]};
		end
		repeat (3) next_cycle();
		for (int i = 0; i < N_REREAD; i++)
		begin
			next_cycle();
			fifo_rd_en = 1'b1;
		end

		// the last push and a pop meet the clear edge
		for (int i = 0; i < 6; i++)
		begin
			next_cycle();
			weight_rd = {1'b1, syn_addrs[i]};
		end
		next_cycle();
		start = 1'b1;
		fifo_rd_en = 1'b1;
		next_cycle();
		for (int i = 0; i < N_CLEAR; i++)
		begin
			next_cycle();
			weight_rd = {1'b1, syn_addrs[N_WEIGHT-1-i]};
		end
		repeat (2) next_cycle();
		for (int i = 0; i < N_CLEAR; i++)
		begin
			next_cycle();
			fifo_rd_en = 1'b1;
		end
		repeat (4) next_cycle();

		if (check_count == 0)
			$display("no comparisons were made during the run");
		$display("errors: %0d, checks: %0d", error_count, check_count);
		if (error_count == 0 && check_count > 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: verif/status_mem_checker.sv
/*
 * Reference model and comparator for the status memory.
 * Shadows every memory and the weight FIFO from the DUT ports,
 * updates on the rising edge and compares outputs on the falling edge.
 */
`include "status_mem_config.svh"

module status_mem_checker
	import neuron_state_pkg::*;
	import synapse_pkg::*;
(
	input  logic           clk_i,
	input  logic           rst_n_i,
	input  logic           start_i,
	input  state_rd_addr_t state_rd_addr_i,
	input  state_en_t      state_rd_en_i,
	input  state_en_t      state_wr_en_i,
	input  state_wr_t      state_wr_i,
	input  syn_rd_t        hist_rd_i,
	input  hist_wr_t       hist_wr_i,
	input  syn_rd_t        weight_rd_i,
	input  weight_wr_t     weight_wr_i,
	input  logic           fifo_rd_en_i,
	input  state_word_t    state_rd_data_i,
	input  hist_t          hist_rd_data_i,
	input  weight_t        weight_rd_data_i,
	input  weight_t        fifo_data_i,
	output int             error_count_o,
	output int             check_count_o
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int FIFO_DEPTH = 1 << `WEIGHT_FIFO_AW;

	state_word_t state_mem [int];
	hist_t hist_mem [int];
	weight_t weight_mem [int];
	// captured neuron per field, present once that field was read
	int state_addr_q [int];
	int field_q = 0;
	int hist_addr_q = 0;
	int weight_addr_q = 0;
	bit hist_cap_q = 1'b0;
	bit weight_cap_q = 1'b0;
	bit push_q = 1'b0;
	bit full;
	// bit 16 marks a word whose value the model knows
	logic [16:0] fifo_q [$];
	int error_cnt = 0;
	int check_cnt = 0;

	assign error_count_o = error_cnt;
	assign check_count_o = check_cnt;

	function automatic int state_key(int field, int neuron);
		return field * (1 << `NEURON_ADDR_W) + neuron;
	endfunction

	function automatic bit field_enabled(state_en_t en, int field);
		case (field)
			0: return en.bias;
			1: return en.potential;
			2: return en.threshold;
			default: return en.post_hist;
		endcase
	endfunction

	// post-history keeps its low bits only, read back zero-extended
	function automatic state_word_t state_expected(int field, int neuron);
		state_word_t word;
		word = state_mem[state_key(field, neuron)];
		if (field == 3)
			word[`STATE_W-1:`HIST_W] = '0;
		return word;
	endfunction

	// word the FIFO takes in: weight at the captured address before this edge
	function automatic logic [16:0] fifo_entry();
		if (weight_cap_q && weight_mem.exists(weight_addr_q))
			return {1'b1, weight_mem[weight_addr_q]};
		return '0;
	endfunction

	task automatic compare(string name, logic [15:0] expected, logic [15:0] actual);
		check_cnt++;
		if (actual !== expected)
		begin
			error_cnt++;
			$display("Fail %s expected %h actual %h at %0t", name, expected, actual, $time);
		end
	endtask

	always @(negedge clk_i)
	begin
		if (rst_n_i)
		begin
			if (state_addr_q.exists(field_q)
				&& state_mem.exists(state_key(field_q, state_addr_q[field_q])))
				compare("state_rd_data_o", state_expected(field_q, state_addr_q[field_q]),
					state_rd_data_i);
			if (hist_cap_q && hist_mem.exists(hist_addr_q))
				compare("hist_rd_data_o", 16'(hist_mem[hist_addr_q]), 16'(hist_rd_data_i));
			if (weight_cap_q && weight_mem.exists(weight_addr_q))
				compare("weight_rd_data_o", weight_mem[weight_addr_q], weight_rd_data_i);
			if (fifo_q.size() > 0 && fifo_q[0][16])
				compare("fifo_data_o", fifo_q[0][15:0], fifo_data_i);
		end
	end

	always @(posedge clk_i)
	begin
		if (!rst_n_i)
		begin
			field_q = 0;
			push_q = 1'b0;
			fifo_q.delete();
		end
		else
		begin
			// clear beats push and pop; a full FIFO drops the push
			full = (fifo_q.size() == FIFO_DEPTH);
			if (start_i)
				fifo_q.delete();
			else
			begin
				if (fifo_rd_en_i && fifo_q.size() > 0)
					void'(fifo_q.pop_front());
				if (push_q && !full)
					fifo_q.push_back(fifo_entry());
			end
			push_q = weight_rd_i.en;

			field_q = int'(state_rd_addr_i.field);
			for (int f = 0; f < 4; f++)
			begin
				if (field_enabled(state_rd_en_i, f))
					state_addr_q[f] = int'(state_rd_addr_i.neuron);
				if (field_enabled(state_wr_en_i, f))
					state_mem[state_key(f, int'(state_wr_i.addr))] = state_wr_i.data;
			end

			if (hist_rd_i.en)
			begin
				hist_addr_q = int'(hist_rd_i.addr);
				hist_cap_q = 1'b1;
			end
			if (hist_wr_i.en)
				hist_mem[int'(hist_wr_i.addr)] = hist_wr_i.data;
			if (weight_rd_i.en)
			begin
				weight_addr_q = int'(weight_rd_i.addr);
				weight_cap_q = 1'b1;
			end
			if (weight_wr_i.en)
				weight_mem[int'(weight_wr_i.addr)] = weight_wr_i.data;
		end
	end

endmodule

// File: hw/status_mem.sv
/*
 * Status memory of one SNN core: neuron state, pre-spike history,
 * synaptic weights and the weight FIFO feeding the learning stage.
 * Every word read from the weight memory is also pushed to the FIFO.
 */
module status_mem
	import neuron_state_pkg::*;
	import synapse_pkg::*;
(
	input  logic           clk_i,
	input  logic           rst_n_i,
	input  logic           start_i,
	input  state_rd_addr_t state_rd_addr_i,
	input  state_en_t      state_rd_en_i,
	input  state_en_t      state_wr_en_i,
	input  state_wr_t      state_wr_i,
	input  syn_rd_t        hist_rd_i,
	input  hist_wr_t       hist_wr_i,
	input  syn_rd_t        weight_rd_i,
	input  weight_wr_t     weight_wr_i,
	input  logic           fifo_rd_en_i,
	output state_word_t    state_rd_data_o,
	output hist_t          hist_rd_data_o,
	output weight_t        weight_rd_data_o,
	output weight_t        fifo_data_o
);

	localparam int SYN_AW = $bits(synapse_addr_t);

	logic fifo_wr_en_q;

	neuron_state_mem u_neuron_state_mem (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.rd_addr_i (state_rd_addr_i),
		.rd_en_i   (state_rd_en_i),
		.wr_en_i   (state_wr_en_i),
		.wr_i      (state_wr_i),
		.rd_data_o (state_rd_data_o)
	);

	// pre-spike history, ports C and D
	addr_reg_ram #(.DATA_W($bits(hist_t)), .ADDR_W(SYN_AW)) u_hist_ram (
		.clk_i     (clk_i),
		.rd_en_i   (hist_rd_i.en),
		.rd_addr_i (hist_rd_i.addr),
		.wr_en_i   (hist_wr_i.en),
		.wr_addr_i (hist_wr_i.addr),
		.wr_data_i (hist_wr_i.data),
		.rd_data_o (hist_rd_data_o)
	);

	// weights, ports E and G
	addr_reg_ram #(.DATA_W($bits(weight_t)), .ADDR_W(SYN_AW)) u_weight_ram (
		.clk_i     (clk_i),
		.rd_en_i   (weight_rd_i.en),
		.rd_addr_i (weight_rd_i.addr),
		.wr_en_i   (weight_wr_i.en),
		.wr_addr_i (weight_wr_i.addr),
		.wr_data_i (weight_wr_i.data),
		.rd_data_o (weight_rd_data_o)
	);

	// push lands when the read data is valid, one cycle after the enable
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			fifo_wr_en_q <= 1'b0;
		end
		else
		begin
			fifo_wr_en_q <= weight_rd_i.en;
		end
	end

	weight_fifo u_weight_fifo (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.clr_i     (start_i),
		.wr_en_i   (fifo_wr_en_q),
		.wr_data_i (weight_rd_data_o),
		.rd_en_i   (fifo_rd_en_i),
		.rd_data_o (fifo_data_o)
	);

endmodule

// File: hw/weight_fifo.sv
/*
 * Single-clock FIFO holding weight words for the learning stage.
 * Head word is visible without a pop; clr_i empties it and wins
 * over a push or pop in the same cycle.
 */
`include "status_mem_config.svh"

module weight_fifo
	import synapse_pkg::*;
(
	input  logic    clk_i,
	input  logic    rst_n_i,
	input  logic    clr_i,
	input  logic    wr_en_i,
	input  weight_t wr_data_i,
	input  logic    rd_en_i,
	output weight_t rd_data_o
);

	localparam int AW = `WEIGHT_FIFO_AW;
	localparam int DEPTH = 1 << AW;

	weight_t mem_q [0:DEPTH-1];
	logic [AW-1:0] wr_ptr_q;
	logic [AW-1:0] rd_ptr_q;
	logic [AW:0] count_q;
	logic push;
	logic pop;

	// overflow drops the word, underflow does nothing
	assign push = wr_en_i && (count_q != DEPTH[AW:0]);
	assign pop = rd_en_i && (count_q != '0);

	always_ff @(posedge clk_i)
	begin
		if (push && !clr_i)
		begin
			mem_q[wr_ptr_q] <= wr_data_i;
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end
		else if (clr_i)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end
		else
		begin
			if (push)
			begin
				wr_ptr_q <= wr_ptr_q + 1'b1;
			end
			if (pop)
			begin
				rd_ptr_q <= rd_ptr_q + 1'b1;
			end
			if (push && !pop)
			begin
				count_q <= count_q + 1'b1;
			end
			else if (pop && !push)
			begin
				count_q <= count_q - 1'b1;
			end
		end
	end

	assign rd_data_o = mem_q[rd_ptr_q];

endmodule

// File: hw/neuron_state_mem.sv
/*
 * Bias, potential, threshold and post-spike history per neuron.
 * One read address and one write address are shared by all four;
 * the field registered from the read address picks the output.
 */
`include "status_mem_config.svh"

module neuron_state_mem
	import neuron_state_pkg::*;
(
	input  logic           clk_i,
	input  logic           rst_n_i,
	input  state_rd_addr_t rd_addr_i,
	input  state_en_t      rd_en_i,
	input  state_en_t      wr_en_i,
	input  state_wr_t      wr_i,
	output state_word_t    rd_data_o
);

	state_word_t bias_rd;
	state_word_t potential_rd;
	state_word_t threshold_rd;
	logic [`HIST_W-1:0] post_hist_rd;
	state_field_e field_q;

	addr_reg_ram #(.DATA_W(`STATE_W), .ADDR_W(`NEURON_ADDR_W)) u_bias_ram (
		.clk_i     (clk_i),
		.rd_en_i   (rd_en_i.bias),
		.rd_addr_i (rd_addr_i.neuron),
		.wr_en_i   (wr_en_i.bias),
		.wr_addr_i (wr_i.addr),
		.wr_data_i (wr_i.data),
		.rd_data_o (bias_rd)
	);

	addr_reg_ram #(.DATA_W(`STATE_W), .ADDR_W(`NEURON_ADDR_W)) u_potential_ram (
		.clk_i     (clk_i),
		.rd_en_i   (rd_en_i.potential),
		.rd_addr_i (rd_addr_i.neuron),
		.wr_en_i   (wr_en_i.potential),
		.wr_addr_i (wr_i.addr),
		.wr_data_i (wr_i.data),
		.rd_data_o (potential_rd)
	);

	addr_reg_ram #(.DATA_W(`STATE_W), .ADDR_W(`NEURON_ADDR_W)) u_threshold_ram (
		.clk_i     (clk_i),
		.rd_en_i   (rd_en_i.threshold),
		.rd_addr_i (rd_addr_i.neuron),
		.wr_en_i   (wr_en_i.threshold),
		.wr_addr_i (wr_i.addr),
		.wr_data_i (wr_i.data),
		.rd_data_o (threshold_rd)
	);

	// history window only, upper data bits dropped
	addr_reg_ram #(.DATA_W(`HIST_W), .ADDR_W(`NEURON_ADDR_W)) u_post_hist_ram (
		.clk_i     (clk_i),
		.rd_en_i   (rd_en_i.post_hist),
		.rd_addr_i (rd_addr_i.neuron),
		.wr_en_i   (wr_en_i.post_hist),
		.wr_addr_i (wr_i.addr),
		.wr_data_i (wr_i.data[`HIST_W-1:0]),
		.rd_data_o (post_hist_rd)
	);

	// loads every cycle, enables or not
	always_ff @(posedge clk_i or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			field_q <= field_bias;
		end
		else
		begin
			field_q <= rd_addr_i.field;
		end
	end

	always_comb
	begin
		case (field_q)
			field_bias:      rd_data_o = bias_rd;
			field_potential: rd_data_o = potential_rd;
			field_threshold: rd_data_o = threshold_rd;
			default:         rd_data_o = {{(`STATE_W-`HIST_W){1'b0}}, post_hist_rd};
		endcase
	end

endmodule

// File: hw/addr_reg_ram.sv
/*
 * Simple dual-port RAM with a registered read address.
 * The read enable captures the address; data follows that address
 * combinationally, so a write to it shows on the next cycle.
 */
module addr_reg_ram #(
	parameter int DATA_W = 16,
	parameter int ADDR_W = 8
) (
	input  logic              clk_i,
	input  logic              rd_en_i,
	input  logic [ADDR_W-1:0] rd_addr_i,
	input  logic              wr_en_i,
	input  logic [ADDR_W-1:0] wr_addr_i,
	input  logic [DATA_W-1:0] wr_data_i,
	output logic [DATA_W-1:0] rd_data_o
);

	logic [DATA_W-1:0] mem_q [0:(1<<ADDR_W)-1];
	logic [ADDR_W-1:0] rd_addr_q;

	always_ff @(posedge clk_i)
	begin
		if (rd_en_i)
		begin
			rd_addr_q <= rd_addr_i;
		end
		if (wr_en_i)
		begin
			mem_q[wr_addr_i] <= wr_data_i;
		end
	end

	// held address keeps driving the output between enables
	assign rd_data_o = mem_q[rd_addr_q];

endmodule

// File: hw/synapse_pkg.sv
/*
 * Types for the neuron-axon memories: pre-spike history and weights.
 * Used by the top level ports C, D, E, G and by the weight FIFO.
 */
`include "status_mem_config.svh"

package synapse_pkg;

	// neuron in the high part so one neuron's axons are contiguous
	typedef struct packed {
		logic [`NEURON_ADDR_W-1:0] neuron;
		logic [`AXON_ADDR_W-1:0] axon;
	} synapse_addr_t;

	typedef logic [`HIST_W-1:0] hist_t;
	typedef logic [`STATE_W-1:0] weight_t;

	typedef struct packed {
		logic en;
		synapse_addr_t addr;
	} syn_rd_t;

	typedef struct packed {
		logic en;
		synapse_addr_t addr;
		hist_t data;
	} hist_wr_t;

	typedef struct packed {
		logic en;
		synapse_addr_t addr;
		weight_t data;
	} weight_wr_t;

endpackage

// File: hw/neuron_state_pkg.sv
/*
 * Types for the per-neuron state memory.
 * Covers port A (field-select read) and port B (multi-field write).
 */
`include "status_mem_config.svh"

package neuron_state_pkg;

	typedef logic [`NEURON_ADDR_W-1:0] neuron_addr_t;
	typedef logic [`STATE_W-1:0] state_word_t;

	// field code sits in the low bits of a port A address
	typedef enum logic [1:0] {
		field_bias      = 2'd0,
		field_potential = 2'd1,
		field_threshold = 2'd2,
		field_post_hist = 2'd3
	} state_field_e;

	typedef struct packed {
		neuron_addr_t neuron;
		state_field_e field;
	} state_rd_addr_t;

	// one enable per state memory, for reads and writes alike
	typedef struct packed {
		logic bias;
		logic potential;
		logic threshold;
		logic post_hist;
	} state_en_t;

	typedef struct packed {
		neuron_addr_t addr;
		state_word_t data;
	} state_wr_t;

endpackage

// File: include/status_mem_config.svh
/*
 * Sizing of the core status memory.
 * Included by the packages and by any module that needs a raw width.
 */
`ifndef STATUS_MEM_CONFIG_SVH
`define STATUS_MEM_CONFIG_SVH

// neuron and axon index widths
`define NEURON_ADDR_W 8
`define AXON_ADDR_W 8

// state words and weights share one width
`define STATE_W 16

// pre and post spike history window
`define HIST_W 8

// 512 entries, enough for two neurons of weights in flight
`define WEIGHT_FIFO_AW 9

`endif
